//--- sim.f
source/lsu_pkg.sv
source/store_format.sv
source/store_buffer.sv
source/load_forward.sv
source/data_mem.sv
source/lsu_top.sv
dv/lsu_chk.sv
dv/lsu_tb.sv

//--- dv/lsu_tb.sv
/*
  Load/store slice testbench
  Applies a table of stores, commits, flushes, loads and idle phases to the
  top level, keeps its own model of the buffered stores and the memory, and
  checks acknowledges, forwarded load data, replays and IO writes
*/
`default_nettype none

module lsu_tb import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ENTRIES = 10;

  typedef enum logic [2:0] {
    OP_STORE, OP_COMMIT1, OP_COMMIT2, OP_FLUSH, OP_LOAD, OP_IDLE
  } op_e;

  // Exp is the expected complete_o for a store and ld_replay_o for a load
  typedef struct packed {
    op_e       op;
    word_t     addr;
    acc_size_e size;
    word_t     data;
    logic      io;
    logic      rnd;
    logic      exp;
  } row_t;

  // Model entry with lane data, byte mask and speculative flag
  typedef struct packed {
    word_t  addr;
    word_t  data;
    bmask_t mask;
    logic   io;
    logic   spec;
  } sb_ent_t;

  logic      core_clock;
  logic      rst;
  logic      st_en;
  word_t     st_addr;
  acc_size_e st_size;
  word_t     st_data;
  logic      st_io;
  rob_tag_t  st_rob;
  logic      commit0;
  logic      commit1;
  logic      flush;
  logic      ld_en;
  word_t     ld_addr;
  acc_size_e ld_size;
  logic      st_full;
  logic      complete;
  rob_tag_t  complete_rob;
  logic      ld_valid;
  word_t     ld_data;
  logic      ld_replay;
  logic      sb_empty;
  logic      io_wr_valid;
  waddr_t    io_wr_addr;
  word_t     io_wr_data;
  bmask_t    io_wr_mask;

  row_t     rows[$];
  sb_ent_t  sb_q[$];
  sb_ent_t  io_seen[$];
  word_t    mem_img [64];
  rob_tag_t rob_next;
  int       errors = 0;
  int       checks = 0;
  int       cycles = 0;
  int       limit  = 0;

  lsu_top #(
    .PHYS    (32),
    .ENTRIES (ENTRIES)
  ) DUT (
    .core_clock_i   (core_clock),
    .rst_i          (rst),
    .st_en_i        (st_en),
    .st_addr_i      (st_addr),
    .st_size_i      (st_size),
    .st_data_i      (st_data),
    .st_io_i        (st_io),
    .st_rob_i       (st_rob),
    .st_full_o      (st_full),
    .complete_o     (complete),
    .complete_rob_o (complete_rob),
    .commit0_i      (commit0),
    .commit1_i      (commit1),
    .flush_i        (flush),
    .ld_en_i        (ld_en),
    .ld_addr_i      (ld_addr),
    .ld_size_i      (ld_size),
    .ld_valid_o     (ld_valid),
    .ld_data_o      (ld_data),
    .ld_replay_o    (ld_replay),
    .sb_empty_o     (sb_empty),
    .io_wr_valid_o  (io_wr_valid),
    .io_wr_addr_o   (io_wr_addr),
    .io_wr_data_o   (io_wr_data),
    .io_wr_mask_o   (io_wr_mask)
  );

  initial core_clock = 1'b0;
  always #50 core_clock = ~core_clock;

  // Stop a run that never reaches the end of the table
  always @(posedge core_clock) begin
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // IO writes are collected here and matched against the model on idle rows
  always @(negedge core_clock) begin
    if (!rst && io_wr_valid) begin
      io_seen.push_back('{addr: {io_wr_addr, 2'b00}, data: io_wr_data,
                          mask: io_wr_mask, io: 1'b1, spec: 1'b0});
    end
  end

  task automatic check_value(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic clear_inputs();
    st_en   = 1'b0;
    st_addr = '0;
    st_size = SIZE_WORD;
    st_data = '0;
    st_io   = 1'b0;
    st_rob  = '0;
    commit0 = 1'b0;
    commit1 = 1'b0;
    flush   = 1'b0;
    ld_en   = 1'b0;
    ld_addr = '0;
    ld_size = SIZE_WORD;
  endtask

  // Inputs change a few ns after the rising edge
  task automatic step_cycle();
    @(posedge core_clock);
    #5;
    clear_inputs();
  endtask

  task automatic add_row(input op_e op, input word_t addr, input acc_size_e size,
                         input word_t data, input logic io, input logic rnd,
                         input logic exp);
    rows.push_back('{op: op, addr: addr, size: size, data: data, io: io,
                     rnd: rnd, exp: exp});
  endtask

  // Lane placement follows the byte offset and the access size
  function automatic sb_ent_t format_access(input word_t addr, input acc_size_e size,
                                            input word_t data, input logic io);
    sb_ent_t e;
    e.addr = addr;
    e.io   = io;
    e.spec = 1'b1;
    case (size)
      SIZE_BYTE: begin
        e.mask = 4'b0001 << addr[1:0];
        e.data = {4{data[7:0]}};
      end
      SIZE_HALF: begin
        e.mask = 4'b0011 << addr[1:0];
        e.data = {2{data[15:0]}};
      end
      default: begin
        e.mask = 4'b1111;
        e.data = data;
      end
    endcase
    return e;
  endfunction

  // Overlapping store bytes replace memory bytes, then the result moves to lane 0
  function automatic word_t load_expect(input row_t r);
    sb_ent_t ld;
    word_t   merged;
    ld     = format_access(r.addr, r.size, '0, 1'b0);
    merged = mem_img[r.addr[7:2]];
    foreach (sb_q[i]) begin
      if (sb_q[i].addr[31:2] == r.addr[31:2] && |(sb_q[i].mask & ld.mask)) begin
        for (int b = 0; b < 4; b++) begin
          if (sb_q[i].mask[b]) begin
            merged[8*b +: 8] = sb_q[i].data[8*b +: 8];
          end
        end
      end
    end
    if (r.exp) begin
      return '0;
    end
    merged = merged >> (8 * r.addr[1:0]);
    case (r.size)
      SIZE_BYTE: return merged & 32'h0000_00ff;
      SIZE_HALF: return merged & 32'h0000_ffff;
      default:   return merged;
    endcase
  endfunction

  task automatic commit_oldest();
    for (int i = 0; i < sb_q.size(); i++) begin
      if (sb_q[i].spec) begin
        sb_q[i].spec = 1'b0;
        break;
      end
    end
  endtask

  // Committed entries have drained, so move them to memory or the IO queue check
  task automatic retire_committed();
    sb_ent_t keep[$];
    sb_ent_t seen;
    foreach (sb_q[i]) begin
      if (sb_q[i].spec) begin
        keep.push_back(sb_q[i]);
      end else if (sb_q[i].io) begin
        if (io_seen.size() == 0) begin
          errors++;
          $display("Missing IO write for address %h", sb_q[i].addr);
        end else begin
          seen = io_seen.pop_front();
          check_value(seen.addr, {sb_q[i].addr[31:2], 2'b00}, "io_wr_addr_o");
          check_value(seen.data, sb_q[i].data, "io_wr_data_o");
          check_value(seen.mask, sb_q[i].mask, "io_wr_mask_o");
        end
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (sb_q[i].mask[b]) begin
            mem_img[sb_q[i].addr[7:2]][8*b +: 8] = sb_q[i].data[8*b +: 8];
          end
        end
      end
    end
    sb_q = keep;
  endtask

  task automatic apply_row(input row_t r);
    sb_ent_t keep[$];
    word_t   data;
    word_t   exp_data;
    case (r.op)
      OP_STORE: begin
        data    = r.rnd ? $urandom() : r.data;
        st_en   = 1'b1;
        st_addr = r.addr;
        st_size = r.size;
        st_data = data;
        st_io   = r.io;
        st_rob  = rob_next;
        // Complete is combinational, so look at it in the middle of the cycle
        #45;
        // Every buffered store in the model is still speculative at a store row,
        // so the model count is the buffer occupancy
        check_value(st_full, sb_q.size() >= ENTRIES, "st_full_o");
        check_value(complete, r.exp, "complete_o");
        if (r.exp) begin
          check_value(complete_rob, rob_next, "complete_rob_o");
          sb_q.push_back(format_access(r.addr, r.size, data, r.io));
        end
        rob_next++;
        step_cycle();
      end
      OP_COMMIT1, OP_COMMIT2: begin
        commit0 = 1'b1;
        commit1 = (r.op == OP_COMMIT2);
        commit_oldest();
        if (r.op == OP_COMMIT2) begin
          commit_oldest();
        end
        step_cycle();
      end
      OP_FLUSH: begin
        flush = 1'b1;
        foreach (sb_q[i]) begin
          if (!sb_q[i].spec) begin
            keep.push_back(sb_q[i]);
          end
        end
        sb_q = keep;
        step_cycle();
      end
      OP_LOAD: begin
        ld_en    = 1'b1;
        ld_addr  = r.addr;
        ld_size  = r.size;
        exp_data = load_expect(r);
        step_cycle();
        step_cycle();
        check_value(ld_valid, 1'b1, "ld_valid_o");
        check_value(ld_replay, r.exp, "ld_replay_o");
        check_value(ld_data, exp_data, "ld_data_o");
      end
      default: begin
        while (sb_empty !== 1'b1) begin
          step_cycle();
        end
        // One more cycle lets the last IO strobe reach the monitor
        step_cycle();
        retire_committed();
      end
    endcase
  endtask

  task automatic fill_table();
    // Fill the buffer with distinct words, the next store finds it full
    for (int i = 0; i < ENTRIES; i++) begin
      add_row(OP_STORE, 4 * i, SIZE_WORD, '0, 1'b0, 1'b1, 1'b1);
    end
    add_row(OP_STORE, 32'h40, SIZE_WORD, 32'h1234_5678, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h08, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h0d, SIZE_BYTE, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_COMMIT2, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_COMMIT2, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_COMMIT1, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_IDLE, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h00, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h12, SIZE_HALF, '0, 1'b0, 1'b0, 1'b0);
    // The committed word survives the flush, the younger ones vanish
    add_row(OP_COMMIT1, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_FLUSH, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_IDLE, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h14, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h18, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    // Partial forwarding, then two overlapping stores force a replay
    add_row(OP_STORE, 32'h02, SIZE_HALF, 32'h0000_beef, 1'b0, 1'b0, 1'b1);
    add_row(OP_LOAD, 32'h00, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h00, SIZE_HALF, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_STORE, 32'h03, SIZE_BYTE, 32'h0000_005a, 1'b0, 1'b0, 1'b1);
    add_row(OP_LOAD, 32'h00, SIZE_WORD, '0, 1'b0, 1'b0, 1'b1);
    add_row(OP_LOAD, 32'h03, SIZE_BYTE, '0, 1'b0, 1'b0, 1'b1);
    add_row(OP_LOAD, 32'h02, SIZE_BYTE, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_STORE, 32'h30, SIZE_WORD, '0, 1'b1, 1'b1, 1'b1);
    add_row(OP_LOAD, 32'h30, SIZE_WORD, '0, 1'b0, 1'b0, 1'b1);
    // Misaligned accesses are refused
    add_row(OP_STORE, 32'h05, SIZE_WORD, 32'hdead_0001, 1'b0, 1'b0, 1'b0);
    add_row(OP_STORE, 32'h07, SIZE_HALF, 32'hdead_0002, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h06, SIZE_WORD, '0, 1'b0, 1'b0, 1'b1);
    add_row(OP_LOAD, 32'h01, SIZE_HALF, '0, 1'b0, 1'b0, 1'b1);
    add_row(OP_COMMIT2, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_COMMIT1, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_IDLE, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h30, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h00, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h03, SIZE_BYTE, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_STORE, 32'h40, SIZE_WORD, '0, 1'b0, 1'b1, 1'b1);
    add_row(OP_STORE, 32'h46, SIZE_HALF, '0, 1'b0, 1'b1, 1'b1);
    add_row(OP_COMMIT2, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_IDLE, '0, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h40, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD, 32'h44, SIZE_WORD, '0, 1'b0, 1'b0, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h6cc7_9e22));
    clear_inputs();
    rst      = 1'b1;
    rob_next = '0;
    foreach (mem_img[i]) begin
      mem_img[i] = '0;
    end
    fill_table();
    limit = rows.size() * 4 + 200;
    repeat (3) @(posedge core_clock);
    #5;
    rst = 1'b0;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    if (io_seen.size() != 0) begin
      errors++;
      $display("Unexpected IO writes: %0d left unmatched", io_seen.size());
    end
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, DUT.u_sb.u_chk.fail_count);
    if (errors == 0 && DUT.u_sb.u_chk.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/lsu_chk.sv
/*
  Store buffer assertions
  Watches the enqueue, drain and empty flags of the store buffer against
  its valid bits and the drain handshake of the data memory, and counts
  every failure
*/
`default_nettype none

module lsu_chk #(
  parameter int ENTRIES = 10
) (
  input wire logic               core_clock_i,
  input wire logic               rst_i,
  input wire logic               full_i,
  input wire logic               complete_i,
  input wire logic               drain_valid_i,
  input wire logic               drain_done_i,
  input wire logic               empty_i,
  input wire logic [ENTRIES-1:0] vld_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions so far
  int fail_count = 0;

  // An acknowledged store had a free slot and sits in the top entry one cycle later
  a_full_no_complete: assert property (@(posedge core_clock_i) disable iff (rst_i)
    complete_i |-> !full_i ##1 vld_i[ENTRIES-1])
    else begin
      fail_count++;
      $error("complete_o rose while the store buffer was full");
    end

  // The memory only retires an entry it was offered for a whole idle cycle before
  a_done_with_valid: assert property (@(posedge core_clock_i) disable iff (rst_i)
    drain_done_i |-> drain_valid_i && $past(drain_valid_i))
    else begin
      fail_count++;
      $error("drain_done arrived without drain_valid");
    end

  // A committed entry that keeps empty low is retired within two cycles
  a_empty_flag: assert property (@(posedge core_clock_i) disable iff (rst_i)
    !empty_i |-> ##[0:1] drain_done_i)
    else begin
      fail_count++;
      $error("empty_o low but no committed entry was drained");
    end

endmodule

bind store_buffer lsu_chk #(
  .ENTRIES (ENTRIES)
) u_chk (
  .core_clock_i  (core_clock_i),
  .rst_i         (rst_i),
  .full_i        (full_o),
  .complete_i    (complete_o),
  .drain_valid_i (drain_valid_o),
  .drain_done_i  (drain_done_i),
  .empty_i       (empty_o),
  .vld_i         (vld_q)
);

`default_nettype wire

//--- source/lsu_top.sv
/*
  Load/store slice top level
  Connects the store and load formatters, the speculative store buffer,
  the load forwarder and the data memory, and hands the depth down
*/
`default_nettype none

module lsu_top import lsu_pkg::*; #(
  parameter int PHYS    = 32,
  parameter int ENTRIES = 10
) (
  input  wire logic      core_clock_i,
  input  wire logic      rst_i,
  input  wire logic      st_en_i,
  input  wire word_t     st_addr_i,
  input  wire acc_size_e st_size_i,
  input  wire word_t     st_data_i,
  input  wire logic      st_io_i,
  input  wire rob_tag_t  st_rob_i,
  output logic           st_full_o,
  output logic           complete_o,
  output rob_tag_t       complete_rob_o,
  input  wire logic      commit0_i,
  input  wire logic      commit1_i,
  input  wire logic      flush_i,
  input  wire logic      ld_en_i,
  input  wire word_t     ld_addr_i,
  input  wire acc_size_e ld_size_i,
  output logic           ld_valid_o,
  output word_t          ld_data_o,
  output logic           ld_replay_o,
  output logic           sb_empty_o,
  output logic           io_wr_valid_o,
  output waddr_t         io_wr_addr_o,
  output word_t          io_wr_data_o,
  output bmask_t         io_wr_mask_o
);

  store_req_t st_req;
  logic       st_mis;
  logic       st_enq;
  store_req_t ld_req;
  logic       ld_mis;
  fwd_reply_t sb_reply;
  store_req_t drain_req;
  logic       drain_valid;
  logic       drain_done;
  waddr_t     lookup_addr;
  bmask_t     lookup_mask;
  waddr_t     mem_addr;
  word_t      mem_data;

  // The word address type is sized from the package width
  if (PHYS != PHYS_W) begin : g_phys_check
    $error("PHYS differs from the package physical address width");
  end

  // Misaligned stores never enter the buffer
  assign st_enq = st_en_i & ~st_mis;

  store_format u_st_fmt (
    .addr_i       (st_addr_i),
    .size_i       (st_size_i),
    .data_i       (st_data_i),
    .io_i         (st_io_i),
    .req_o        (st_req),
    .misaligned_o (st_mis)
  );

  // Loads carry no data and are never IO on this path
  store_format u_ld_fmt (
    .addr_i       (ld_addr_i),
    .size_i       (ld_size_i),
    .data_i       ('0),
    .io_i         (1'b0),
    .req_o        (ld_req),
    .misaligned_o (ld_mis)
  );

  store_buffer #(
    .ENTRIES (ENTRIES)
  ) u_sb (
    .core_clock_i   (core_clock_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .enq_i          (st_enq),
    .enq_req_i      (st_req),
    .enq_rob_i      (st_rob_i),
    .full_o         (st_full_o),
    .complete_o     (complete_o),
    .complete_rob_o (complete_rob_o),
    .commit0_i      (commit0_i),
    .commit1_i      (commit1_i),
    .lookup_addr_i  (lookup_addr),
    .lookup_mask_i  (lookup_mask),
    .reply_o        (sb_reply),
    .drain_o        (drain_req),
    .drain_valid_o  (drain_valid),
    .drain_done_i   (drain_done),
    .empty_o        (sb_empty_o)
  );

  load_forward u_lf (
    .core_clock_i    (core_clock_i),
    .rst_i           (rst_i),
    .ld_en_i         (ld_en_i),
    .ld_req_i        (ld_req),
    .ld_misaligned_i (ld_mis),
    .lookup_addr_o   (lookup_addr),
    .lookup_mask_o   (lookup_mask),
    .reply_i         (sb_reply),
    .mem_addr_o      (mem_addr),
    .mem_data_i      (mem_data),
    .ld_valid_o      (ld_valid_o),
    .ld_data_o       (ld_data_o),
    .ld_replay_o     (ld_replay_o)
  );

  data_mem u_mem (
    .core_clock_i  (core_clock_i),
    .rst_i         (rst_i),
    .wr_i          (drain_req),
    .wr_valid_i    (drain_valid),
    .wr_done_o     (drain_done),
    .rd_addr_i     (mem_addr),
    .rd_data_o     (mem_data),
    .io_wr_valid_o (io_wr_valid_o),
    .io_wr_addr_o  (io_wr_addr_o),
    .io_wr_data_o  (io_wr_data_o),
    .io_wr_mask_o  (io_wr_mask_o)
  );

endmodule

`default_nettype wire

//--- source/data_mem.sv
/*
  Data memory with drain port
  A 64 word byte enabled array written by committed stores from the store
  buffer. Each drain takes two cycles, IO stores skip the array and pulse
  the external IO write port instead. Loads read the array combinationally
*/
`default_nettype none

module data_mem import lsu_pkg::*; (
  input  wire logic       core_clock_i,
  input  wire logic       rst_i,
  input  wire store_req_t wr_i,
  input  wire logic       wr_valid_i,
  output logic            wr_done_o,
  input  wire waddr_t     rd_addr_i,
  output word_t           rd_data_o,
  output logic            io_wr_valid_o,
  output waddr_t          io_wr_addr_o,
  output word_t           io_wr_data_o,
  output bmask_t          io_wr_mask_o
);

  localparam int DEPTH = 64;
  localparam int IDX_W = $clog2(DEPTH);

  word_t             mem_q [DEPTH];
  drain_state_e      state_q;
  drain_state_e      state_d;
  logic [IDX_W-1:0]  wr_idx;

  // Only the low word address bits index the array
  assign wr_idx = wr_i.addr[IDX_W-1:0];

  // Idle sees a pending drain, the write phase performs it
  always_comb begin
    state_d = state_q;
    case (state_q)
      DRAIN_IDLE:  if (wr_valid_i) state_d = DRAIN_WRITE;
      DRAIN_WRITE: state_d = DRAIN_IDLE;
      default:     state_d = DRAIN_IDLE;
    endcase
  end

  always_ff @(posedge core_clock_i) begin
    if (rst_i) begin
      state_q <= DRAIN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Done tells the buffer to retire the entry at this edge
  assign wr_done_o = (state_q == DRAIN_WRITE) && wr_valid_i;

  always_ff @(posedge core_clock_i) begin
    if (rst_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_done_o && !wr_i.io) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_i.mask[b]) begin
          mem_q[wr_idx][8*b +: 8] <= wr_i.data[8*b +: 8];
        end
      end
    end
  end

  // IO strobe lasts one cycle after the write edge
  always_ff @(posedge core_clock_i) begin
    if (rst_i) begin
      io_wr_valid_o <= 1'b0;
    end else begin
      io_wr_valid_o <= wr_done_o & wr_i.io;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (wr_done_o) begin
      io_wr_addr_o <= wr_i.addr;
      io_wr_data_o <= wr_i.data;
      io_wr_mask_o <= wr_i.mask;
    end
  end

  assign rd_data_o = mem_q[rd_addr_i[IDX_W-1:0]];

endmodule

`default_nettype wire

//--- source/load_forward.sv
/*
  Load forwarder
  Registers a formatted load, looks it up in the store buffer and reads the
  data memory in the following cycle, merges forwarded store bytes over
  memory bytes, and returns the result aligned to lane 0 or asks for a replay
*/
`default_nettype none

module load_forward import lsu_pkg::*; (
  input  wire logic       core_clock_i,
  input  wire logic       rst_i,
  input  wire logic       ld_en_i,
  input  wire store_req_t ld_req_i,
  input  wire logic       ld_misaligned_i,
  output waddr_t          lookup_addr_o,
  output bmask_t          lookup_mask_o,
  input  wire fwd_reply_t reply_i,
  output waddr_t          mem_addr_o,
  input  wire word_t      mem_data_i,
  output logic            ld_valid_o,
  output word_t           ld_data_o,
  output logic            ld_replay_o
);

  // Request stage
  logic       req_v_q;
  store_req_t req_q;
  logic       mis_q;

  word_t      merged;
  word_t      shifted;
  word_t      aligned;
  logic [1:0] lane_off;
  logic       replay;

  always_ff @(posedge core_clock_i) begin
    if (rst_i) begin
      req_v_q <= 1'b0;
    end else begin
      req_v_q <= ld_en_i;
    end
  end

  always_ff @(posedge core_clock_i) begin
    req_q <= ld_req_i;
    mis_q <= ld_misaligned_i;
  end

  // Buffer lookup and memory read share the registered word address
  assign lookup_addr_o = req_q.addr;
  assign lookup_mask_o = req_q.mask;
  assign mem_addr_o    = req_q.addr;

  // More than one store or an IO store in the way cannot be forwarded
  assign replay = mis_q | (reply_i.hit & ~reply_i.resolvable);

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (reply_i.hit && reply_i.resolvable && reply_i.mask[b]) begin
        merged[8*b +: 8] = reply_i.data[8*b +: 8];
      end else begin
        merged[8*b +: 8] = mem_data_i[8*b +: 8];
      end
    end
  end

  // The lowest set mask bit is the byte offset of the load
  always_comb begin
    if (req_q.mask[0]) begin
      lane_off = 2'd0;
    end else if (req_q.mask[1]) begin
      lane_off = 2'd1;
    end else if (req_q.mask[2]) begin
      lane_off = 2'd2;
    end else begin
      lane_off = 2'd3;
    end
  end

  assign shifted = merged >> {lane_off, 3'b000};

  // Size comes back from the mask shape, upper bytes are zero filled
  always_comb begin
    if (&req_q.mask) begin
      aligned = shifted;
    end else if (req_q.mask == 4'b0011 || req_q.mask == 4'b1100) begin
      aligned = {16'h0000, shifted[15:0]};
    end else begin
      aligned = {24'h000000, shifted[7:0]};
    end
  end

  // Result stage, a replayed load returns zero
  always_ff @(posedge core_clock_i) begin
    if (rst_i) begin
      ld_valid_o  <= 1'b0;
      ld_replay_o <= 1'b0;
    end else begin
      ld_valid_o  <= req_v_q;
      ld_replay_o <= req_v_q & replay;
    end
  end

  always_ff @(posedge core_clock_i) begin
    ld_data_o <= replay ? '0 : aligned;
  end

endmodule

`default_nettype wire

//--- source/store_buffer.sv
/*
  Speculative store buffer
  Keeps stores in program order in a shifting array that fills at the top
  and compacts toward entry 0. Commit pulses clear the speculative bit of
  the oldest stores, a flush drops the speculative ones, the oldest
  committed store is offered for draining, and loads are checked against
  every valid entry for byte overlap
*/
`default_nettype none

module store_buffer import lsu_pkg::*; #(
  parameter int ENTRIES = 10
) (
  input  wire logic       core_clock_i,
  input  wire logic       rst_i,
  input  wire logic       flush_i,
  input  wire logic       enq_i,
  input  wire store_req_t enq_req_i,
  input  wire rob_tag_t   enq_rob_i,
  output logic            full_o,
  output logic            complete_o,
  output rob_tag_t        complete_rob_o,
  input  wire logic       commit0_i,
  input  wire logic       commit1_i,
  input  wire waddr_t     lookup_addr_i,
  input  wire bmask_t     lookup_mask_i,
  output fwd_reply_t      reply_o,
  output store_req_t      drain_o,
  output logic            drain_valid_o,
  input  wire logic       drain_done_i,
  output logic            empty_o
);

  // Entry payload, index 0 is the oldest store
  store_req_t ent_q [ENTRIES];
  store_req_t ent_d [ENTRIES];

  logic [ENTRIES-1:0] vld_q;
  logic [ENTRIES-1:0] vld_d;
  logic [ENTRIES-1:0] spec_q;
  logic [ENTRIES-1:0] spec_d;

  // Per entry state after commit, flush and drain, before compaction
  logic [ENTRIES-1:0] vld_keep;
  logic [ENTRIES-1:0] spec_keep;

  logic [ENTRIES-1:0] shift;
  logic [ENTRIES-1:0] spec_first;
  logic [ENTRIES-1:0] spec_second;
  logic [ENTRIES-1:0] drain_sel;
  logic [ENTRIES-1:0] conflict;
  logic               conflict_one;
  logic               accept;
  store_req_t         hit_ent;

  assign full_o = &vld_q;

  // A store is taken only with room and no flush in the same cycle
  assign accept = enq_i & ~full_o & ~flush_i;

  // Stores finish execution as soon as they are buffered
  assign complete_o     = accept;
  assign complete_rob_o = enq_rob_i;

  // An entry moves down when a hole exists at or below it
  for (genvar i = 0; i < ENTRIES; i++) begin : g_shift
    assign shift[i] = ~(&vld_q[i:0]);
  end

  // Oldest two speculative entries for commit, oldest committed for drain
  always_comb begin
    spec_first  = '0;
    spec_second = '0;
    drain_sel   = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (vld_q[i] && spec_q[i]) begin
        if (spec_first == '0) begin
          spec_first[i] = 1'b1;
        end else if (spec_second == '0) begin
          spec_second[i] = 1'b1;
        end
      end
      if (vld_q[i] && !spec_q[i] && drain_sel == '0) begin
        drain_sel[i] = 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      // Either pulse commits the oldest, both together commit the next one too
      spec_keep[i] = spec_q[i]
                   & ~(spec_first[i] & (commit0_i | commit1_i))
                   & ~(spec_second[i] & commit0_i & commit1_i);
      // Speculative entries die on flush, committed ones leave once drained
      vld_keep[i]  = vld_q[i]
                   & (spec_keep[i] ? ~flush_i : ~(drain_sel[i] & drain_done_i));
    end
  end

  // Compaction toward entry 0, new stores come in at the top
  always_comb begin
    for (int i = 0; i < ENTRIES - 1; i++) begin
      ent_d[i]  = shift[i] ? ent_q[i+1] : ent_q[i];
      vld_d[i]  = shift[i] ? vld_keep[i+1] : vld_keep[i];
      spec_d[i] = shift[i] ? spec_keep[i+1] : spec_keep[i];
    end
    ent_d[ENTRIES-1]  = shift[ENTRIES-1] ? enq_req_i : ent_q[ENTRIES-1];
    vld_d[ENTRIES-1]  = shift[ENTRIES-1] ? accept : vld_keep[ENTRIES-1];
    spec_d[ENTRIES-1] = shift[ENTRIES-1] ? 1'b1 : spec_keep[ENTRIES-1];
  end

  always_ff @(posedge core_clock_i) begin
    if (rst_i) begin
      vld_q  <= '0;
      spec_q <= '0;
    end else begin
      vld_q  <= vld_d;
      spec_q <= spec_d;
    end
  end

  always_ff @(posedge core_clock_i) begin
    ent_q <= ent_d;
  end

  // Same word and at least one shared byte lane
  for (genvar i = 0; i < ENTRIES; i++) begin : g_cmp
    assign conflict[i] = vld_q[i]
                       && (ent_q[i].addr == lookup_addr_i)
                       && |(ent_q[i].mask & lookup_mask_i);
  end

  // Forwarding is only safe from a single matching store
  assign conflict_one = |conflict && ((conflict & (conflict - 1'b1)) == '0);

  always_comb begin
    hit_ent = '0;
    drain_o = '0;
    // Later indices overwrite, so the youngest overlapping store wins
    for (int i = 0; i < ENTRIES; i++) begin
      if (conflict[i]) begin
        hit_ent = ent_q[i];
      end
      if (drain_sel[i]) begin
        drain_o = ent_q[i];
      end
    end
  end

  always_comb begin
    reply_o            = '0;
    reply_o.data       = hit_ent.data;
    reply_o.mask       = hit_ent.mask;
    reply_o.hit        = |conflict;
    // IO stores never forward, their side effects must reach the device
    reply_o.resolvable = conflict_one & ~hit_ent.io;
  end

  assign drain_valid_o = |drain_sel;

  // No committed store is left waiting for the memory
  assign empty_o = ~|(vld_q & ~spec_q);

endmodule

`default_nettype wire

//--- source/store_format.sv
/*
  Store and load formatter
  Turns a byte address, an access size and register data into a word
  address, a byte lane mask and lane replicated data, and flags accesses
  that cross their natural alignment
*/
`default_nettype none

module store_format import lsu_pkg::*; (
  input  wire word_t     addr_i,
  input  wire acc_size_e size_i,
  input  wire word_t     data_i,
  input  wire logic      io_i,
  output store_req_t     req_o,
  output logic           misaligned_o
);

  logic [1:0] offset;
  bmask_t     mask;
  word_t      lane_data;

  // Low address bits select the starting byte lane
  assign offset = addr_i[1:0];

  always_comb begin
    mask         = 4'b0000;
    lane_data    = data_i;
    misaligned_o = 1'b0;
    case (size_i)
      SIZE_BYTE: begin
        // A byte is copied into every lane, the mask picks the one written
        mask      = 4'b0001 << offset;
        lane_data = {4{data_i[7:0]}};
      end
      SIZE_HALF: begin
        mask         = 4'b0011 << offset;
        lane_data    = {2{data_i[15:0]}};
        // Odd halfword addresses would straddle two lane pairs
        misaligned_o = offset[0];
      end
      SIZE_WORD: begin
        mask         = 4'b1111;
        lane_data    = data_i;
        misaligned_o = (offset != 2'b00);
      end
      default: begin
        // Unused size code, refused like a misaligned access
        mask         = 4'b0000;
        misaligned_o = 1'b1;
      end
    endcase
  end

  always_comb begin
    req_o      = '0;
    req_o.addr = addr_i[PHYS_W-1:2];
    req_o.data = lane_data;
    req_o.mask = mask;
    req_o.io   = io_i;
  end

endmodule

`default_nettype wire

//--- source/lsu_pkg.sv
/*
  Load/store unit shared definitions
  Holds the width types, the access size and drain phase encodings, and the
  packed records that carry a formatted store and a forwarding reply between
  the formatter, the store buffer, the load forwarder and the data memory
*/
`default_nettype none

package lsu_pkg;

  // Physical address width the word address type is built from
  localparam int PHYS_W = 32;

  // Data word, byte lane mask and ROB tag
  typedef logic [31:0] word_t;
  typedef logic [3:0] bmask_t;
  typedef logic [4:0] rob_tag_t;

  // Word address, the byte offset bits are dropped
  typedef logic [PHYS_W-3:0] waddr_t;

  // Access size as decoded by the core
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } acc_size_e;

  // Drain phase of the data memory write port
  typedef enum logic {
    DRAIN_IDLE  = 1'b0,
    DRAIN_WRITE = 1'b1
  } drain_state_e;

  // One store after lane alignment, also reused for a formatted load
  typedef struct packed {
    waddr_t addr;
    word_t  data;
    bmask_t mask;
    logic   io;
  } store_req_t;

  // Answer of the store buffer to a load conflict lookup
  typedef struct packed {
    word_t  data;
    bmask_t mask;
    logic   hit;
    logic   resolvable;
  } fwd_reply_t;

endpackage

`default_nettype wire
